// File: rtl/ks10_config.svh
`ifndef KS10_CONFIG_SVH
`define KS10_CONFIG_SVH

////////////////////
// Word and address sizes
////////////////////

// Full data word, bits 0 to 35
`define WORD_WIDTH      36

// Virtual address occupies word bits 14 to 35
`define ADDR_WIDTH      22

// ACs plus scratch storage
`define RAMFILE_DEPTH   256

// Microword number field
`define NUM_WIDTH       12

// Address bits that must be zero for an AC reference
`define ACREF_HI        18
`define ACREF_LO        31

////////////////////
// Microword select codes
////////////////////

// DBUS select field
`define DBUS_SEL_FLAGS      2'd0
`define DBUS_SEL_DP         2'd1
`define DBUS_SEL_RAMFILE    2'd2
`define DBUS_SEL_DBM        2'd3

// DBM select field
`define DBM_SEL_MEMDATA     2'd0
`define DBM_SEL_VMA         2'd1
`define DBM_SEL_NUMBER      2'd2

`endif

// File: rtl/busPkg.sv
`include "ks10_config.svh"

package busPkg;

   ////////////////////
   // Datapath words
   ////////////////////

   // Bits numbered big-endian, bit 0 is the MSB
   typedef logic [0:`WORD_WIDTH-1] word_t;

   // Address keeps its word bit numbers, 14 to 35
   typedef logic [`WORD_WIDTH-`ADDR_WIDTH:`WORD_WIDTH-1] vmaAddr_t;

   // Cycle flags carried alongside the VMA
   typedef struct packed
   {
      logic readCycle;
      logic writeCycle;
      logic physical;
   } vmaFlags_t;

   ////////////////////
   // Wishbone classic
   ////////////////////

   // Master to slave
   typedef struct packed
   {
      logic     cyc;
      logic     stb;
      logic     we;
      vmaAddr_t adr;
      word_t    datW;
   } wbReq_t;

   // Slave to master
   typedef struct packed
   {
      logic  ack;
      word_t datR;
   } wbRsp_t;

endpackage

// File: rtl/cromPkg.sv
`include "ks10_config.svh"

package cromPkg;

   import busPkg::*;

   // What drives the data bus
   typedef enum logic [1:0]
   {
      Flags   = `DBUS_SEL_FLAGS,
      Dp      = `DBUS_SEL_DP,
      Ramfile = `DBUS_SEL_RAMFILE,
      Dbm     = `DBUS_SEL_DBM
   } dbusSel_t;

   // What the DBM mux supplies
   // Code 3 is unused
   typedef enum logic [1:0]
   {
      MemData = `DBM_SEL_MEMDATA,
      Vma     = `DBM_SEL_VMA,
      Number  = `DBM_SEL_NUMBER
   } dbmSel_t;

   ////////////////////
   // Microword
   ////////////////////

   // Only the fields this section decodes
   typedef struct packed
   {
      dbusSel_t              dbusSel;
      dbmSel_t               dbmSel;
      logic                  loadVma;
      // Flags loaded into the VMA with the address
      vmaFlags_t             vmaFlags;
      // Kick off a main-memory cycle
      logic                  memStart;
      // Store the data bus into the ramfile
      logic                  ramfileWrite;
      logic [`NUM_WIDTH-1:0] number;
   } cromWord_t;

endpackage

// File: rtl/vmaReg.sv
`include "ks10_config.svh"

module vmaReg
   import busPkg::*;
   import cromPkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  cromWord_t crom,
   input  word_t     dp,
   output vmaAddr_t  vmaAddr,
   output vmaFlags_t vmaFlags,
   output logic      acRef
);

   ////////////////////
   // VMA register
   ////////////////////

   // Address comes from the right 22 bits of the datapath
   // Flags come straight from the microword
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         vmaAddr  <= '0;
         vmaFlags <= '0;
      end
      else if (crom.loadVma)
      begin
         vmaAddr  <= dp[`WORD_WIDTH-`ADDR_WIDTH:`WORD_WIDTH-1];
         vmaFlags <= crom.vmaFlags;
      end
   end

   ////////////////////
   // AC reference
   ////////////////////

   // Lowest 16 words of a section
   // Only bits 32 to 35 may be set
   // Section bits 14 to 17 are ignored
   // Physical references never hit the ACs
   always_comb
   begin
      acRef = ~vmaFlags.physical & (vmaAddr[`ACREF_HI:`ACREF_LO] == '0);
   end

endmodule

// File: rtl/ramfile.sv
`include "ks10_config.svh"

module ramfile
   import busPkg::*;
(
   input  logic                              clk,
   input  logic                              write,
   input  logic [0:$clog2(`RAMFILE_DEPTH)-1] addr,
   input  word_t                             writeData,
   output word_t                             readData
);

   ////////////////////
   // Storage
   ////////////////////

   // Words 0 to 15 are the ACs
   // Everything above is microcode scratch
   word_t mem [0:`RAMFILE_DEPTH-1];

   // Write from the data bus
   // New value readable after the edge
   always_ff @(posedge clk)
   begin
      if (write)
      begin
         mem[addr] <= writeData;
      end
   end

   // Asynchronous read
   // Same cycle as the address
   always_comb
   begin
      readData = mem[addr];
   end

endmodule

// File: rtl/dbm.sv
`include "ks10_config.svh"

module dbm
   import busPkg::*;
   import cromPkg::*;
(
   input  dbmSel_t               dbmSel,
   input  word_t                 memData,
   input  vmaAddr_t              vmaAddr,
   input  vmaFlags_t             vmaFlags,
   input  logic [`NUM_WIDTH-1:0] number,
   output word_t                 dbmData
);

   // Flags in bits 0 to 2
   // Zero fill to bit 13
   // Address in bits 14 to 35
   word_t vmaWord;

   // Number field right justified
   word_t numberWord;

   always_comb
   begin
      vmaWord    = {vmaFlags,
                    {(`WORD_WIDTH - `ADDR_WIDTH - $bits(vmaFlags_t)){1'b0}},
                    vmaAddr};
      numberWord = {{(`WORD_WIDTH - `NUM_WIDTH){1'b0}}, number};
   end

   ////////////////////
   // DBM mux
   ////////////////////

   always_comb
   begin
      case (dbmSel)
         MemData: dbmData = memData;
         Vma:     dbmData = vmaWord;
         Number:  dbmData = numberWord;
         // Unused code
         default: dbmData = '0;
      endcase
   end

endmodule

// File: rtl/dbus.sv
module dbus
   import busPkg::*;
   import cromPkg::*;
(
   input  dbusSel_t dbusSel,
   input  logic     readCycle,
   input  logic     acRef,
   input  word_t    pcFlags,
   input  word_t    dp,
   input  word_t    ramfileData,
   input  word_t    dbmData,
   output word_t    dbus
);

   ////////////////////
   // Force ramfile
   ////////////////////

   // AC read goes to the ramfile instead of memory
   // No cache here so AC references are the only source
   logic forceRamfile;

   always_comb
   begin
      forceRamfile = acRef & readCycle;
   end

   ////////////////////
   // Bus mux
   ////////////////////

   // Simple 4-way 36-bit mux
   always_comb
   begin
      case (dbusSel)
         Flags:   dbus = pcFlags;
         Dp:      dbus = dp;
         Ramfile: dbus = ramfileData;
         // DBM unless the ramfile is forced
         Dbm:     dbus = forceRamfile ? ramfileData : dbmData;
      endcase
   end

endmodule

// File: rtl/memBusMaster.sv
module memBusMaster
   import busPkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      memStart,
   input  logic      acRef,
   input  vmaAddr_t  vmaAddr,
   input  vmaFlags_t vmaFlags,
   input  word_t     dp,
   input  wbRsp_t    wbRsp,
   output wbReq_t    wbReq,
   output word_t     memData,
   output logic      busy
);

   // Idle or waiting for ack
   typedef enum logic
   {
      Idle,
      Cycle
   } state_t;

   state_t   state;
   logic     weReg;
   vmaAddr_t adrReg;
   word_t    datWReg;

   // Start only when free and not an AC reference
   logic     start;

   always_comb
   begin
      start = memStart & ~acRef & (state == Idle);
   end

   ////////////////////
   // Control state
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state   <= Idle;
         weReg   <= 1'b0;
         memData <= '0;
      end
      else
      begin
         case (state)
            Idle:
            begin
               if (start)
               begin
                  state <= Cycle;
                  weReg <= vmaFlags.writeCycle;
               end
            end
            Cycle:
            begin
               // Slave may stretch the cycle
               if (wbRsp.ack)
               begin
                  state <= Idle;
                  // Latch read data on ack
                  if (!weReg)
                  begin
                     memData <= wbRsp.datR;
                  end
               end
            end
            default: state <= Idle;
         endcase
      end
   end

   // Address and write data held until ack
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         adrReg  <= vmaAddr;
         datWReg <= dp;
      end
   end

   ////////////////////
   // Bus outputs
   ////////////////////

   // Single transfers so stb tracks cyc
   always_comb
   begin
      busy  = (state == Cycle);
      wbReq = '{cyc: busy, stb: busy, we: weReg, adr: adrReg, datW: datWReg};
   end

endmodule

// File: rtl/dbusPath.sv
`include "ks10_config.svh"

module dbusPath
   import busPkg::*;
   import cromPkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  cromWord_t crom,
   input  word_t     dp,
   input  word_t     pcFlags,
   input  wbRsp_t    wbRsp,
   output word_t     dbus,
   output wbReq_t    wbReq,
   output logic      busy
);

   vmaAddr_t  vmaAddr;
   vmaFlags_t vmaFlags;
   logic      acRef;
   word_t     ramfileData;
   word_t     dbmData;
   word_t     memData;

   ////////////////////
   // Address side
   ////////////////////

   vmaReg vmaRegInst
   (
      .clk      (clk),
      .reset    (reset),
      .crom     (crom),
      .dp       (dp),
      .vmaAddr  (vmaAddr),
      .vmaFlags (vmaFlags),
      .acRef    (acRef)
   );

   // Indexed by the low VMA bits
   // Written from the data bus itself
   ramfile ramfileInst
   (
      .clk       (clk),
      .write     (crom.ramfileWrite),
      .addr      (vmaAddr[`WORD_WIDTH-$clog2(`RAMFILE_DEPTH):`WORD_WIDTH-1]),
      .writeData (dbus),
      .readData  (ramfileData)
   );

   ////////////////////
   // Main memory
   ////////////////////

   memBusMaster memBusMasterInst
   (
      .clk      (clk),
      .reset    (reset),
      .memStart (crom.memStart),
      .acRef    (acRef),
      .vmaAddr  (vmaAddr),
      .vmaFlags (vmaFlags),
      .dp       (dp),
      .wbRsp    (wbRsp),
      .wbReq    (wbReq),
      .memData  (memData),
      .busy     (busy)
   );

   ////////////////////
   // Bus muxes
   ////////////////////

   dbm dbmInst
   (
      .dbmSel   (crom.dbmSel),
      .memData  (memData),
      .vmaAddr  (vmaAddr),
      .vmaFlags (vmaFlags),
      .number   (crom.number),
      .dbmData  (dbmData)
   );

   // Read flag from the loaded VMA
   dbus dbusInst
   (
      .dbusSel     (crom.dbusSel),
      .readCycle   (vmaFlags.readCycle),
      .acRef       (acRef),
      .pcFlags     (pcFlags),
      .dp          (dp),
      .ramfileData (ramfileData),
      .dbmData     (dbmData),
      .dbus        (dbus)
   );

endmodule

// File: tests/memModel.sv
module memModel
   import busPkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  wbReq_t wbReq,
   output wbRsp_t wbRsp
);

   // Sparse store, only words that were written
   word_t store [vmaAddr_t];

   // Fixed seed so wait states repeat run to run
   integer seed = 19;

   // Wait cycles left before ack
   logic [1:0] waitCnt;

   // Unwritten words read as the address mixed with a fixed pattern
   function automatic word_t fillWord(input vmaAddr_t adr);
      return word_t'(adr) ^ 36'h5A5A5A5A5;
   endfunction

   ////////////////////
   // Slave response
   ////////////////////

   always @(posedge clk)
   begin
      if (reset)
      begin
         wbRsp.ack  <= 1'b0;
         wbRsp.datR <= '0;
         waitCnt    <= 2'($random(seed));
      end
      else if (wbRsp.ack)
      begin
         // Master drops cyc on this same edge
         wbRsp.ack <= 1'b0;
         waitCnt   <= 2'($random(seed));
      end
      else if (wbReq.cyc && wbReq.stb)
      begin
         if (waitCnt != 2'd0)
         begin
            waitCnt <= waitCnt - 2'd1;
         end
         else
         begin
            wbRsp.ack <= 1'b1;
            if (wbReq.we)
            begin
               store[wbReq.adr] = wbReq.datW;
            end
            else
            begin
               wbRsp.datR <= store.exists(wbReq.adr) ? store[wbReq.adr] : fillWord(wbReq.adr);
            end
         end
      end
   end

endmodule

// File: tests/dbusPathTb.sv
module dbusPathTb
   import busPkg::*;
   import cromPkg::*;
();

   localparam int testCount     = 6;
   localparam int cyclesPerTest = 200;
   localparam int resetCycles   = 8;

   // Cycle flag combinations used below
   localparam vmaFlags_t readFlags  = '{readCycle: 1'b1, writeCycle: 1'b0, physical: 1'b0};
   localparam vmaFlags_t writeFlags = '{readCycle: 1'b0, writeCycle: 1'b1, physical: 1'b0};
   localparam vmaFlags_t physRead   = '{readCycle: 1'b1, writeCycle: 1'b0, physical: 1'b1};

   logic      clk = 1'b0;
   logic      reset;
   cromWord_t crom;
   word_t     dp;
   word_t     pcFlags;
   wbRsp_t    wbRsp;
   word_t     dbus;
   wbReq_t    wbReq;
   logic      busy;

   int errCount   = 0;
   int checkCount = 0;
   int testNum    = 0;

   dbusPath uut
   (
      .clk     (clk),
      .reset   (reset),
      .crom    (crom),
      .dp      (dp),
      .pcFlags (pcFlags),
      .wbRsp   (wbRsp),
      .dbus    (dbus),
      .wbReq   (wbReq),
      .busy    (busy)
   );

   // Main memory behind the Wishbone port
   memModel slave
   (
      .clk   (clk),
      .reset (reset),
      .wbReq (wbReq),
      .wbRsp (wbRsp)
   );

   always #5 clk = ~clk;

   ////////////////////
   // Bus protocol
   ////////////////////

   // Single transfers so stb and busy both follow cyc
   assert property (@(posedge clk) disable iff (reset)
      (wbReq.stb == wbReq.cyc) && (busy == wbReq.cyc))
   else
   begin
      $display("Protocol error at %0t: stb or busy does not follow cyc", $time);
      errCount++;
   end

   // Request held steady while the slave stalls
   assert property (@(posedge clk) disable iff (reset)
      wbReq.cyc && !wbRsp.ack |=> wbReq.cyc && (wbReq.adr == $past(wbReq.adr))
         && (wbReq.we == $past(wbReq.we)) && (wbReq.datW == $past(wbReq.datW)))
   else
   begin
      $display("Protocol error at %0t: request dropped or changed before ack", $time);
      errCount++;
   end

   // Cycle ends on the ack edge
   assert property (@(posedge clk) disable iff (reset)
      wbReq.cyc && wbRsp.ack |=> !wbReq.cyc && !busy)
   else
   begin
      $display("Protocol error at %0t: cycle still open after ack", $time);
      errCount++;
   end

   ////////////////////
   // Helpers
   ////////////////////

   task automatic compareWord(input string name, input word_t got, input word_t exp);
      checkCount++;
      assert (got === exp)
      else
      begin
         $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
         errCount++;
      end
   endtask

   task automatic compareBit(input string name, input logic got, input logic exp);
      checkCount++;
      assert (got === exp)
      else
      begin
         $display("Mismatch at %0t: %s = %b, expected %b", $time, name, got, exp);
         errCount++;
      end
   endtask

   // New microword and datapath word on the rising edge
   task automatic drive(input cromWord_t w, input word_t dpVal);
      @(posedge clk);
      crom <= w;
      dp   <= dpVal;
   endtask

   // Load the VMA and start a cycle then wait for busy to fall
   task automatic runMemCycle(input vmaFlags_t flags, input vmaAddr_t addr, input word_t wdata);
      cromWord_t w;
      w          = '0;
      w.loadVma  = 1'b1;
      w.vmaFlags = flags;
      drive(w, word_t'(addr));
      w          = '0;
      w.memStart = 1'b1;
      drive(w, wdata);
      drive('0, '0);
      @(negedge clk);
      compareBit("busy", busy, 1'b1);
      compareBit("wbReq.cyc", wbReq.cyc, 1'b1);
      compareBit("wbReq.we", wbReq.we, flags.writeCycle);
      compareWord("wbReq.adr", word_t'(wbReq.adr), word_t'(addr));
      if (flags.writeCycle)
      begin
         compareWord("wbReq.datW", wbReq.datW, wdata);
      end
      // Slave decides how long this takes
      while (busy)
      begin
         @(negedge clk);
      end
   endtask

   // Latched read data through DBM onto the bus
   task automatic checkMemData(input word_t exp);
      cromWord_t w;
      w         = '0;
      w.dbusSel = Dbm;
      w.dbmSel  = MemData;
      drive(w, '0);
      @(negedge clk);
      compareWord("dbus", dbus, exp);
   endtask

   function automatic word_t unwrittenPattern(input vmaAddr_t addr);
      return word_t'(addr) ^ 36'h5A5A5A5A5;
   endfunction

   task automatic finishTest(input string name, input int errStart);
      testNum++;
      $display("Test %0d %s: %s", testNum, name, (errCount == errStart) ? "ok" : "errors found");
   endtask

   ////////////////////
   // Watchdog
   ////////////////////

   initial
   begin
      repeat (resetCycles + testCount * cyclesPerTest) @(posedge clk);
      $display("Watchdog expired at %0t, a test did not finish", $time);
      $display("TEST FAILED");
      $finish;
   end

   ////////////////////
   // Tests
   ////////////////////

   initial
   begin
      int errStart;
      cromWord_t w;
      reset   = 1'b1;
      crom    = '0;
      dp      = '0;
      pcFlags = '0;
      repeat (resetCycles) @(posedge clk);
      reset <= 1'b0;

      // Flags and Dp straight through
      errStart = errCount;
      @(negedge clk);
      compareBit("busy", busy, 1'b0);
      compareBit("wbReq.cyc", wbReq.cyc, 1'b0);
      w         = '0;
      w.dbusSel = Flags;
      @(posedge clk);
      crom    <= w;
      pcFlags <= 36'h800012345;
      @(negedge clk);
      compareWord("dbus", dbus, 36'h800012345);
      w.dbusSel = Dp;
      drive(w, 36'h76543210F);
      @(negedge clk);
      compareWord("dbus", dbus, 36'h76543210F);
      finishTest("pass-through", errStart);

      // Scratch word 0x40 through the ramfile
      errStart  = errCount;
      w         = '0;
      w.loadVma = 1'b1;
      drive(w, word_t'(22'h000040));
      w              = '0;
      w.dbusSel      = Dp;
      w.ramfileWrite = 1'b1;
      drive(w, 36'h123456789);
      w         = '0;
      w.dbusSel = Ramfile;
      drive(w, '0);
      @(negedge clk);
      compareWord("dbus", dbus, 36'h123456789);
      finishTest("ramfile write and read", errStart);

      // Write then read back plus one unwritten word
      errStart = errCount;
      runMemCycle(writeFlags, 22'h001234, 36'hCAFE01234);
      runMemCycle(readFlags, 22'h001234, '0);
      checkMemData(36'hCAFE01234);
      runMemCycle(readFlags, 22'h002345, '0);
      checkMemData(unwrittenPattern(22'h002345));
      finishTest("memory write and read", errStart);

      // AC 5 read comes from the ramfile without a bus cycle
      errStart  = errCount;
      w         = '0;
      w.loadVma = 1'b1;
      drive(w, word_t'(22'd5));
      w              = '0;
      w.dbusSel      = Dp;
      w.ramfileWrite = 1'b1;
      drive(w, 36'h0ACAC0005);
      w          = '0;
      w.loadVma  = 1'b1;
      w.vmaFlags = readFlags;
      drive(w, word_t'(22'd5));
      w          = '0;
      w.memStart = 1'b1;
      w.dbusSel  = Dbm;
      w.dbmSel   = MemData;
      drive(w, '0);
      @(negedge clk);
      compareWord("dbus", dbus, 36'h0ACAC0005);
      w.memStart = 1'b0;
      repeat (3)
      begin
         drive(w, '0);
         @(negedge clk);
         compareBit("busy", busy, 1'b0);
         compareBit("wbReq.cyc", wbReq.cyc, 1'b0);
         compareWord("dbus", dbus, 36'h0ACAC0005);
      end
      finishTest("forced ramfile", errStart);

      // Physical read of the same low address goes to memory
      errStart = errCount;
      runMemCycle(physRead, 22'd5, '0);
      checkMemData(unwrittenPattern(22'd5));
      finishTest("physical low address", errStart);

      // VMA word layout and number field
      errStart   = errCount;
      w          = '0;
      w.loadVma  = 1'b1;
      w.vmaFlags = physRead;
      drive(w, word_t'(22'h2ABCDE));
      w         = '0;
      w.dbusSel = Dbm;
      w.dbmSel  = Vma;
      drive(w, '0);
      @(negedge clk);
      compareWord("dbus", dbus, {physRead, 11'b0, 22'h2ABCDE});
      w.dbmSel = Number;
      w.number = 12'hABC;
      drive(w, '0);
      @(negedge clk);
      compareWord("dbus", dbus, word_t'(12'hABC));
      finishTest("VMA and number words", errStart);

      $display("Tests: %0d  checks: %0d  errors: %0d", testNum, checkCount, errCount);
      if (errCount == 0)
      begin
         $display("TEST PASSED");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: dbusPath.f
+incdir+rtl
rtl/busPkg.sv
rtl/cromPkg.sv
rtl/vmaReg.sv
rtl/ramfile.sv
rtl/dbm.sv
rtl/dbus.sv
rtl/memBusMaster.sv
rtl/dbusPath.sv
tests/memModel.sv
tests/dbusPathTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = dbusPathTb
RTL_TOP   = dbusPath
FILELIST  = dbusPath.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

# Full project lint, testbench included
lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build, run, then decide on the pass line in the log
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
